//--- verilog/elev_settings.svh
// elevator settings
// floor count, floor number width, travel time and door timing
`ifndef ELEV_SETTINGS_SVH
`define ELEV_SETTINGS_SVH

`define ELEV_FLOORS        8	// floors served by the car
`define ELEV_FLOOR_BITS    3	// bits in a floor number
`define ELEV_TRAVEL_CYCLES 4	// engine cycles per one-floor move

`define ELEV_DOOR_HOLD     6	// cycles door command stays open
`define ELEV_DOOR_CLOSE    2	// cycles door command stays close

`endif

//--- verilog/elev_call_pkg.sv
// elevator call types
// floor numbers, per-floor masks and the grouped button inputs
`include "elev_settings.svh"

package elev_call_pkg;

	// floor number, 0 is the ground floor
	typedef logic [`ELEV_FLOOR_BITS-1:0] floor_t;

	// one bit per floor, bit n is floor n
	typedef logic [`ELEV_FLOORS-1:0] floor_mask_t;

	// button levels as sampled each cycle
	typedef struct packed {
		floor_mask_t car;	// inside the car
		floor_mask_t hall_up;	// landing, going up
		floor_mask_t hall_down;	// landing, going down
	} button_set_t;

endpackage

//--- verilog/elev_motion_pkg.sv
// elevator motion types
// engine and door command encodings, state machine states and car status

package elev_motion_pkg;

	typedef enum logic [1:0] {
		engine_idle = 2'd0,
		engine_down = 2'd1,
		engine_up   = 2'd2
	} engine_e;

	typedef enum logic [1:0] {
		door_idle  = 2'd0,
		door_open  = 2'd1,
		door_close = 2'd2
	} door_e;

	typedef enum logic [1:0] {
		door_shut,	// no sequence running
		door_holding,	// door commanded open
		door_closing	// door commanded close
	} door_state_e;

	typedef enum logic [1:0] {
		travel_parked,
		travel_moving,
		travel_serving	// waiting on the door sequence
	} travel_state_e;

	typedef struct packed {
		elev_call_pkg::floor_t floor;
		engine_e engine;
	} car_status_t;

endpackage

//--- verilog/call_register.sv
// call register
// latches car and hall calls per floor and clears a floor when it is served
`timescale 1ns/100ps
`include "elev_settings.svh"

module call_register (
	input  logic                        clk,
	input  logic                        reset,
	input  elev_call_pkg::button_set_t  buttons,
	input  elev_call_pkg::floor_t       car_floor,
	input  logic                        serve,
	output elev_call_pkg::floor_mask_t  pending
);

	elev_call_pkg::button_set_t calls;	// latched calls
	elev_call_pkg::floor_mask_t clear_mask;	// floor being served

	always_comb begin
		for (int i = 0; i < `ELEV_FLOORS; i++) begin
			clear_mask[i] = serve && (int'(car_floor) == i);
		end
	end

	// clear wins over a press in the same cycle
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			calls <= '0;
		end else begin
			calls.car       <= (calls.car | buttons.car) & ~clear_mask;
			calls.hall_up   <= (calls.hall_up | buttons.hall_up) & ~clear_mask;
			calls.hall_down <= (calls.hall_down | buttons.hall_down) & ~clear_mask;
		end
	end

	// scheduler treats every kind of call alike
	assign pending = calls.car | calls.hall_up | calls.hall_down;

endmodule

//--- verilog/door_sequencer.sv
// door sequencer
// open, hold and close sequence with open and close button overrides
`timescale 1ns/100ps
`include "elev_settings.svh"

module door_sequencer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     door_request,
	input  logic                     open_btn,
	input  logic                     close_btn,
	output elev_motion_pkg::door_e   door,
	output logic                     door_busy,
	output logic                     serve
);

	localparam int door_max = (`ELEV_DOOR_HOLD > `ELEV_DOOR_CLOSE) ?
		`ELEV_DOOR_HOLD : `ELEV_DOOR_CLOSE;
	localparam int cnt_bits = (door_max > 1) ? $clog2(door_max) : 1;

	localparam logic [cnt_bits-1:0] hold_load  = cnt_bits'(`ELEV_DOOR_HOLD - 1);
	localparam logic [cnt_bits-1:0] close_load = cnt_bits'(`ELEV_DOOR_CLOSE - 1);

	elev_motion_pkg::door_state_e state;
	logic [cnt_bits-1:0]          count;	// cycles left in this phase

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= elev_motion_pkg::door_shut;
			count <= '0;
		end else begin
			case (state)
				elev_motion_pkg::door_shut: begin
					if (door_request) begin
						state <= elev_motion_pkg::door_holding;
						count <= hold_load;
					end
				end
				elev_motion_pkg::door_holding: begin
					if (open_btn) begin
						count <= hold_load;	// restart hold
					end else if (close_btn || count == '0) begin
						state <= elev_motion_pkg::door_closing;
						count <= close_load;
					end else begin
						count <= count - 1'b1;
					end
				end
				elev_motion_pkg::door_closing: begin
					if (open_btn) begin
						state <= elev_motion_pkg::door_holding;	// reopen, same service
						count <= hold_load;
					end else if (count == '0) begin
						state <= elev_motion_pkg::door_shut;
					end else begin
						count <= count - 1'b1;
					end
				end
				default: begin
					state <= elev_motion_pkg::door_shut;
				end
			endcase
		end
	end

	always_comb begin
		case (state)
			elev_motion_pkg::door_holding: door = elev_motion_pkg::door_open;
			elev_motion_pkg::door_closing: door = elev_motion_pkg::door_close;
			default:                       door = elev_motion_pkg::door_idle;
		endcase
	end

	assign door_busy = (state != elev_motion_pkg::door_shut);
	assign serve     = (state == elev_motion_pkg::door_shut) && door_request;	// once per sequence

endmodule

//--- verilog/travel_controller.sv
// travel controller
// picks the direction, moves the car floor by floor and decides where to stop
`timescale 1ns/100ps
`include "elev_settings.svh"

module travel_controller (
	input  logic                            clk,
	input  logic                            reset,
	input  elev_call_pkg::floor_mask_t      pending,
	input  logic                            door_busy,
	input  logic                            open_btn,
	output logic                            door_request,
	output elev_motion_pkg::car_status_t    car
);

	localparam int cnt_bits = (`ELEV_TRAVEL_CYCLES > 1) ? $clog2(`ELEV_TRAVEL_CYCLES) : 1;
	localparam logic [cnt_bits-1:0] travel_load = cnt_bits'(`ELEV_TRAVEL_CYCLES - 1);

	elev_motion_pkg::travel_state_e state;
	elev_call_pkg::floor_t          floor;
	logic                           dir_up;	// 1 up, 0 down
	logic [cnt_bits-1:0]            count;	// engine cycles left on this floor

	elev_call_pkg::floor_t step_floor;	// floor the car is heading to
	elev_call_pkg::floor_t decide_floor;	// floor the decision refers to
	logic                  calls_above;
	logic                  calls_below;
	logic                  call_here;
	logic                  calls_ahead;
	logic                  calls_behind;

	assign step_floor   = dir_up ? floor + 1'b1 : floor - 1'b1;
	// while moving, decisions look at the floor being reached
	assign decide_floor = (state == elev_motion_pkg::travel_moving) ? step_floor : floor;

	always_comb begin
		calls_above = 1'b0;
		calls_below = 1'b0;
		for (int i = 0; i < `ELEV_FLOORS; i++) begin
			if (pending[i] && i > int'(decide_floor))
				calls_above = 1'b1;
			if (pending[i] && i < int'(decide_floor))
				calls_below = 1'b1;
		end
	end

	assign call_here    = pending[decide_floor];
	assign calls_ahead  = dir_up ? calls_above : calls_below;
	assign calls_behind = dir_up ? calls_below : calls_above;

	assign door_request = (state == elev_motion_pkg::travel_parked) && !door_busy &&
		(call_here || open_btn);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= elev_motion_pkg::travel_parked;
			floor  <= '0;
			dir_up <= 1'b1;
			count  <= '0;
		end else begin
			case (state)
				elev_motion_pkg::travel_parked: begin
					if (door_busy) begin
						state <= elev_motion_pkg::travel_parked;
					end else if (call_here || open_btn) begin
						state <= elev_motion_pkg::travel_serving;
					end else if (calls_ahead) begin
						state <= elev_motion_pkg::travel_moving;
						count <= travel_load;
					end else if (calls_behind) begin
						state  <= elev_motion_pkg::travel_moving;
						dir_up <= ~dir_up;	// nothing left ahead
						count  <= travel_load;
					end
				end
				elev_motion_pkg::travel_moving: begin
					if (count == '0) begin
						floor <= step_floor;
						count <= travel_load;
						// stop to serve, or re-plan when the run is over
						if (call_here || !calls_ahead)
							state <= elev_motion_pkg::travel_parked;
					end else begin
						count <= count - 1'b1;
					end
				end
				elev_motion_pkg::travel_serving: begin
					if (!door_busy)
						state <= elev_motion_pkg::travel_parked;
				end
				default: begin
					state <= elev_motion_pkg::travel_parked;
				end
			endcase
		end
	end

	always_comb begin
		car.floor = floor;
		if (state == elev_motion_pkg::travel_moving)
			car.engine = dir_up ? elev_motion_pkg::engine_up : elev_motion_pkg::engine_down;
		else
			car.engine = elev_motion_pkg::engine_idle;
	end

endmodule

//--- verilog/elevator.sv
// elevator controller
// single car for eight floors, calls and door run beside the travel control
`timescale 1ns/100ps

module elevator (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        open_btn,
	input  logic                        close_btn,
	input  elev_call_pkg::button_set_t  buttons,
	output elev_motion_pkg::engine_e    engine,
	output elev_motion_pkg::door_e      door,
	output elev_call_pkg::floor_t       level_display
);

	elev_call_pkg::floor_mask_t   pending;	// calls waiting, any kind
	elev_motion_pkg::car_status_t car;
	logic                         door_request;
	logic                         door_busy;
	logic                         serve;	// floor of car is being served

	call_register u_call_register (
		.clk       (clk),
		.reset     (reset),
		.buttons   (buttons),
		.car_floor (car.floor),
		.serve     (serve),
		.pending   (pending)
	);

	door_sequencer u_door_sequencer (
		.clk          (clk),
		.reset        (reset),
		.door_request (door_request),
		.open_btn     (open_btn),
		.close_btn    (close_btn),
		.door         (door),
		.door_busy    (door_busy),
		.serve        (serve)
	);

	travel_controller u_travel_controller (
		.clk          (clk),
		.reset        (reset),
		.pending      (pending),
		.door_busy    (door_busy),
		.open_btn     (open_btn),
		.door_request (door_request),
		.car          (car)
	);

	assign engine        = car.engine;
	assign level_display = car.floor;

endmodule

//--- testbench/tb_clock.sv
// testbench clock and reset
// free running clock, reset held low for a set number of cycles
`timescale 1ns/100ps

module tb_clock #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b0;	// asserted from time zero
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

//--- testbench/tb_elevator.sv
// elevator testbench
// random calls and door buttons, checked against a call and motion model
`timescale 1ns/100ps
`include "elev_settings.svh"

module tb_elevator;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	localparam int stim_cycles  = 3000;
	localparam int drain_cycles = 600;
	localparam int watchdog_ns  = (reset_cycles + stim_cycles + drain_cycles + 200) * clk_period;

	logic                       clk;
	logic                       reset;
	logic                       open_btn;
	logic                       close_btn;
	elev_call_pkg::button_set_t buttons;
	elev_motion_pkg::engine_e   engine;
	elev_motion_pkg::door_e     door;
	elev_call_pkg::floor_t      level_display;

	int seed = 53331;

	elev_call_pkg::floor_mask_t model_pending;
	elev_call_pkg::floor_mask_t prev_btn;	// presses the DUT takes at the next edge
	logic                       prev_open;
	logic                       prev_close;
	elev_motion_pkg::door_e     prev_door;
	elev_motion_pkg::engine_e   prev_engine;
	elev_call_pkg::floor_t      model_floor;
	logic                       model_dir_up;
	int                         eng_run;	// engine cycles since last floor step
	int                         open_run;
	int                         close_run;
	logic                       btn_seen;	// door button during this open phase

	tb_clock #(.period_ns(clk_period), .reset_cycles(reset_cycles)) u_tb_clock (
		.clk   (clk),
		.reset (reset)
	);

	elevator u_elevator (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.close_btn     (close_btn),
		.buttons       (buttons),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

	task automatic abort_run(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic compare_engine(string name, elev_motion_pkg::engine_e got,
		elev_motion_pkg::engine_e exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_door(string name, elev_motion_pkg::door_e got,
		elev_motion_pkg::door_e exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_floor(string name, elev_call_pkg::floor_t got,
		elev_call_pkg::floor_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_mask(string name, elev_call_pkg::floor_mask_t got,
		elev_call_pkg::floor_mask_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	// any call strictly past floor f in the given direction
	function automatic logic calls_beyond(elev_call_pkg::floor_mask_t mask,
		elev_call_pkg::floor_t f, logic up);
		for (int i = 0; i < `ELEV_FLOORS; i++) begin
			if (mask[i] && (up ? i > int'(f) : i < int'(f)))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic track_motion();
		elev_call_pkg::floor_t expect_floor;
		logic                  going_up;
		going_up = (engine == elev_motion_pkg::engine_up);
		if (door != elev_motion_pkg::door_idle && engine != elev_motion_pkg::engine_idle)
			abort_run("engine running while the door is not idle");
		if (level_display != model_floor) begin
			if (prev_engine == elev_motion_pkg::engine_idle)
				abort_run("floor changed while the engine was idle");
			expect_floor = (prev_engine == elev_motion_pkg::engine_up) ?
				model_floor + 1'b1 : model_floor - 1'b1;
			compare_floor("level_display", level_display, expect_floor);
			if (eng_run != `ELEV_TRAVEL_CYCLES)
				abort_run($sformatf("floor step after %0d engine cycles instead of %0d",
					eng_run, `ELEV_TRAVEL_CYCLES));
			if (engine != elev_motion_pkg::engine_idle) begin
				compare_engine("engine", engine, prev_engine);
				if (model_pending[level_display])
					abort_run("car passed a floor with a pending call");
				if (!calls_beyond(model_pending, level_display, going_up))
					abort_run("car kept moving with no call ahead");
			end
			eng_run = (engine != elev_motion_pkg::engine_idle) ? 1 : 0;
		end else if (engine == elev_motion_pkg::engine_idle) begin
			if (eng_run != 0)
				abort_run("engine stopped between floors");
		end else if (prev_engine == elev_motion_pkg::engine_idle) begin
			if (model_pending[model_floor] || prev_open)
				abort_run("car left a floor it should have served");
			if (model_pending == '0)
				abort_run("car started with no call pending");
			if (!calls_beyond(model_pending, model_floor, going_up))
				abort_run("car started away from every call");
			if (going_up != model_dir_up && calls_beyond(model_pending, model_floor, model_dir_up))
				abort_run("car reversed with calls still ahead");
			eng_run = 1;
		end else begin
			compare_engine("engine", engine, prev_engine);
			eng_run++;
			if (eng_run > `ELEV_TRAVEL_CYCLES)
				abort_run("engine ran past one floor without a floor step");
		end
		if (engine != elev_motion_pkg::engine_idle)
			model_dir_up = going_up;
		model_floor = level_display;
	endtask

	task automatic track_door();
		if (prev_door == elev_motion_pkg::door_idle && door == elev_motion_pkg::door_open) begin
			if (prev_engine != elev_motion_pkg::engine_idle)
				abort_run("door opened while the car was moving");
			if (!model_pending[model_floor] && !prev_open)
				abort_run("door opened with no call here and no open button");
			open_run = 1;
			btn_seen = open_btn || close_btn;
		end else if (prev_door == elev_motion_pkg::door_close &&
			door == elev_motion_pkg::door_open) begin
			if (!prev_open)
				abort_run("door reopened without the open button");
			open_run = 1;
			btn_seen = open_btn || close_btn;
		end else if (prev_door == elev_motion_pkg::door_open &&
			door == elev_motion_pkg::door_open) begin
			if (prev_close && !prev_open)
				abort_run("close button did not end the hold");
			open_run++;
			if (!btn_seen && open_run > `ELEV_DOOR_HOLD)
				abort_run("door held open longer than the hold time");
			btn_seen = btn_seen || open_btn || close_btn;
		end else if (prev_door == elev_motion_pkg::door_open &&
			door == elev_motion_pkg::door_close) begin
			if (!btn_seen && open_run != `ELEV_DOOR_HOLD)
				abort_run($sformatf("door held open %0d cycles instead of %0d",
					open_run, `ELEV_DOOR_HOLD));
			close_run = 1;
		end else if (prev_door == elev_motion_pkg::door_close &&
			door == elev_motion_pkg::door_close) begin
			if (prev_open)
				abort_run("open button did not reopen the door");
			close_run++;
			if (close_run > `ELEV_DOOR_CLOSE)
				abort_run("door kept closing past the close time");
		end else if (prev_door == elev_motion_pkg::door_close &&
			door == elev_motion_pkg::door_idle) begin
			if (prev_open)
				abort_run("open button did not reopen the door");
			if (close_run != `ELEV_DOOR_CLOSE)
				abort_run($sformatf("door closed %0d cycles instead of %0d",
					close_run, `ELEV_DOOR_CLOSE));
		end else if (door != prev_door) begin
			abort_run("door command skipped a phase");
		end
	endtask

	// outputs and buttons are stable on the falling edge
	always @(negedge clk) begin : monitor
		if (!reset) begin
			model_pending = '0;
			prev_btn      = '0;
			prev_open     = 1'b0;
			prev_close    = 1'b0;
			prev_door     = elev_motion_pkg::door_idle;
			prev_engine   = elev_motion_pkg::engine_idle;
			model_floor   = '0;
			model_dir_up  = 1'b1;
			eng_run       = 0;
			open_run      = 0;
			close_run     = 0;
			btn_seen      = 1'b0;
		end else begin
			track_motion();
			track_door();
			model_pending = model_pending | prev_btn;
			if (prev_door == elev_motion_pkg::door_idle && door == elev_motion_pkg::door_open)
				model_pending[model_floor] = 1'b0;	// served on door open
			compare_mask("pending", u_elevator.pending, model_pending);
			prev_btn    = buttons.car | buttons.hall_up | buttons.hall_down;
			prev_open   = open_btn;
			prev_close  = close_btn;
			prev_door   = door;
			prev_engine = engine;
		end
	end

	initial begin : stimulus
		int unsigned               pick;
		logic [3*`ELEV_FLOORS-1:0] press;
		buttons   = '0;
		open_btn  = 1'b0;
		close_btn = 1'b0;
		@(negedge clk);
		compare_engine("engine", engine, elev_motion_pkg::engine_idle);
		compare_door("door", door, elev_motion_pkg::door_idle);
		compare_floor("level_display", level_display, '0);
		wait (reset === 1'b1);
		@(negedge clk);
		compare_engine("engine", engine, elev_motion_pkg::engine_idle);
		compare_door("door", door, elev_motion_pkg::door_idle);
		compare_floor("level_display", level_display, '0);
		for (int cycle = 0; cycle < stim_cycles; cycle++) begin
			@(posedge clk);
			pick  = $unsigned($random(seed));
			press = '0;
			if (pick % 16 == 0)
				press[(pick / 16) % (3 * `ELEV_FLOORS)] = 1'b1;	// one button at a time
			buttons   <= elev_call_pkg::button_set_t'(press);
			open_btn  <= ($unsigned($random(seed)) % 64) == 0;
			close_btn <= ($unsigned($random(seed)) % 40) == 0;
		end
		@(posedge clk);
		buttons   <= '0;
		open_btn  <= 1'b0;
		close_btn <= 1'b0;
		repeat (drain_cycles) @(posedge clk);
		@(negedge clk);
		#1;
		if (model_pending != '0)
			abort_run("calls still pending after the drain phase");
		compare_mask("pending", u_elevator.pending, '0);
		compare_engine("engine", engine, elev_motion_pkg::engine_idle);
		compare_door("door", door, elev_motion_pkg::door_idle);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		abort_run("watchdog timeout, the run did not finish in time");
	end

endmodule

//--- sim.f
+incdir+verilog
verilog/elev_call_pkg.sv
verilog/elev_motion_pkg.sv
verilog/call_register.sv
verilog/door_sequencer.sv
verilog/travel_controller.sv
verilog/elevator.sv
testbench/tb_clock.sv
testbench/tb_elevator.sv
